// File: src.f
+incdir+.
dot_pkg.sv
lane_multiplier.sv
dot_product_pipe.sv
result_buffer.sv
block_reader.sv
dnn_accelerator.sv
tb_clock_gen.sv
tb_dnn_accelerator.sv

// File: tb_dnn_accelerator.sv
// ==========================================================
// Two full rounds of 64 operations, each drained by a block read
// Stops at the first error. Timeout after 2000 cycles
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "dot_macros.svh"

module tb_dnn_accelerator;

    // Two rounds take about 320 cycles plus up to 192 gap cycles in round 2
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int VEC_W = `DOT_LANES * `DOT_OPERAND_W;

    logic              clk;
    logic              rst_n;
    logic              mac_en;
    logic              mac_rdy;
    dot_pkg::operand_t mac_a0;
    dot_pkg::operand_t mac_a1;
    dot_pkg::operand_t mac_a2;
    dot_pkg::operand_t mac_a3;
    dot_pkg::operand_t mac_b0;
    dot_pkg::operand_t mac_b1;
    dot_pkg::operand_t mac_b2;
    dot_pkg::operand_t mac_b3;
    logic              block_read_en;
    logic              block_read_rdy;
    logic              mem_val_valid;
    dot_pkg::result_t  mem_val_data;

    // Expected results in issue order
    dot_pkg::result_t  expected_q [$];
    dot_pkg::result_t  expected_value;
    int unsigned       cycle_count;
    int unsigned       last_issue_cycle;
    int unsigned       beat_count;
    int unsigned       error_count;
    int unsigned       seed_value;
    logic [VEC_W-1:0]  a_vec;
    logic [VEC_W-1:0]  b_vec;
    logic              accepted;
    int                gap;

    tb_clock_gen clock_gen0 (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dnn_accelerator dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .mac_en         (mac_en),
        .mac_rdy        (mac_rdy),
        .mac_a0         (mac_a0),
        .mac_a1         (mac_a1),
        .mac_a2         (mac_a2),
        .mac_a3         (mac_a3),
        .mac_b0         (mac_b0),
        .mac_b1         (mac_b1),
        .mac_b2         (mac_b2),
        .mac_b3         (mac_b3),
        .block_read_en  (block_read_en),
        .block_read_rdy (block_read_rdy),
        .mem_val_valid  (mem_val_valid),
        .mem_val_data   (mem_val_data)
    );

    // ==========================================================
    // Reference model and check helpers
    // ==========================================================
    // Sum of the four lane products at 34 bits
    function automatic dot_pkg::result_t dot_ref(input logic [VEC_W-1:0] av,
                                                 input logic [VEC_W-1:0] bv);
        dot_pkg::result_t acc;
        acc = '0;
        for (int i = 0; i < `DOT_LANES; i++) begin
            acc = acc + dot_pkg::result_t'(av[i*`DOT_OPERAND_W +: `DOT_OPERAND_W])
                      * dot_pkg::result_t'(bv[i*`DOT_OPERAND_W +: `DOT_OPERAND_W]);
        end
        return acc;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("Mismatch %s: expected 0x%0h, got 0x%0h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("Error: %s", what);
        $display("Test failures found");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic show_phase(input dot_pkg::buffer_state_t phase);
        $display("Cycle %0d: buffer expected in %s", cycle_count, phase.name());
    endtask

    // ==========================================================
    // Stimulus helpers
    // ==========================================================
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Drive one request for a cycle and record it when mac_rdy took it
    task automatic issue_op(input logic [VEC_W-1:0] av, input logic [VEC_W-1:0] bv,
                            output logic taken);
        mac_a0 = av[15:0];
        mac_a1 = av[31:16];
        mac_a2 = av[47:32];
        mac_a3 = av[63:48];
        mac_b0 = bv[15:0];
        mac_b1 = bv[31:16];
        mac_b2 = bv[47:32];
        mac_b3 = bv[63:48];
        mac_en = 1'b1;
        taken  = mac_rdy;
        next_cycle();
        mac_en = 1'b0;
        if (taken) begin
            expected_q.push_back(dot_ref(av, bv));
            last_issue_cycle = cycle_count;
        end
    endtask

    task automatic pulse_block_read();
        block_read_en = 1'b1;
        next_cycle();
        block_read_en = 1'b0;
    endtask

    // Memory turns full only once the last result has landed
    task automatic wait_full();
        while (block_read_rdy !== 1'b1) begin
            next_cycle();
        end
        check_value("block_read_rdy latency", 64'd9, cycle_count - last_issue_cycle);
        check_value("mac_rdy", 64'd0, mac_rdy);
        show_phase(dot_pkg::BUF_FULL);
    endtask

    // Expect 64 back-to-back beats and then an idle buffer
    task automatic read_block(input int unsigned beats_before);
        check_value("beat count before read", beats_before, beat_count);
        pulse_block_read();
        show_phase(dot_pkg::BUF_READING);
        while (mem_val_valid !== 1'b1) begin
            next_cycle();
        end
        for (int i = 0; i < `DOT_DEPTH; i++) begin
            check_value("mem_val_valid", 64'd1, mem_val_valid);
            next_cycle();
        end
        check_value("mem_val_valid", 64'd0, mem_val_valid);
        check_value("beat count", beats_before + `DOT_DEPTH, beat_count);
        check_value("expected queue size", 64'd0, expected_q.size());
        check_value("mac_rdy", 64'd1, mac_rdy);
        check_value("block_read_rdy", 64'd0, block_read_rdy);
        show_phase(dot_pkg::BUF_IDLE);
    endtask

    // ==========================================================
    // Output compare and timeout
    // ==========================================================
    // Falling edge keeps sampling clear of the registered outputs
    always @(negedge clk) begin
        if (rst_n && mem_val_valid) begin
            if (expected_q.size() == 0) begin
                report_failure("mem_val_valid beat with no result outstanding");
            end else begin
                expected_value = expected_q.pop_front();
                check_value("mem_val_data", expected_value, mem_val_data);
                beat_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $fatal(1, "Timeout");
        end
    end

    // ==========================================================
    // Test sequence
    // ==========================================================
    initial begin
        mac_en           = 1'b0;
        mac_a0           = '0;
        mac_a1           = '0;
        mac_a2           = '0;
        mac_a3           = '0;
        mac_b0           = '0;
        mac_b1           = '0;
        mac_b2           = '0;
        mac_b3           = '0;
        block_read_en    = 1'b0;
        cycle_count      = 0;
        last_issue_cycle = 0;
        beat_count       = 0;
        error_count      = 0;
        seed_value       = 32'hc2f2c74f;
        void'($urandom(seed_value));

        @(posedge rst_n);
        next_cycle();
        // Reset values
        check_value("mac_rdy", 64'd1, mac_rdy);
        check_value("block_read_rdy", 64'd0, block_read_rdy);
        check_value("mem_val_valid", 64'd0, mem_val_valid);

        // Block read in idle is ignored
        pulse_block_read();
        repeat (4) next_cycle();
        check_value("beat count", 64'd0, beat_count);
        check_value("block_read_rdy", 64'd0, block_read_rdy);

        // Round 1 back to back with corner operands at both ends
        show_phase(dot_pkg::BUF_WRITING);
        for (int i = 0; i < `DOT_DEPTH; i++) begin
            if (i == 0 || i == `DOT_DEPTH - 1) begin
                a_vec = '1;
                b_vec = '1;
            end else if (i == 1) begin
                a_vec = '0;
                b_vec = '0;
            end else begin
                a_vec = {$urandom, $urandom};
                b_vec = {$urandom, $urandom};
            end
            issue_op(a_vec, b_vec, accepted);
            check_value("mac_rdy at issue", 64'd1, accepted);
            check_value("block_read_rdy", 64'd0, block_read_rdy);
        end
        check_value("mac_rdy", 64'd0, mac_rdy);

        // Extra requests past the quota are refused
        repeat (3) begin
            issue_op({$urandom, $urandom}, {$urandom, $urandom}, accepted);
            check_value("mac_rdy at extra issue", 64'd0, accepted);
            check_value("block_read_rdy", 64'd0, block_read_rdy);
        end

        // Block read while still writing is ignored
        pulse_block_read();
        check_value("block_read_rdy", 64'd0, block_read_rdy);
        wait_full();
        check_value("beat count", 64'd0, beat_count);
        read_block(0);

        // Round 2 with random gaps between requests
        show_phase(dot_pkg::BUF_WRITING);
        for (int i = 0; i < `DOT_DEPTH; i++) begin
            gap = $urandom_range(0, 3);
            repeat (gap) next_cycle();
            a_vec = {$urandom, $urandom};
            b_vec = {$urandom, $urandom};
            issue_op(a_vec, b_vec, accepted);
            check_value("mac_rdy at issue", 64'd1, accepted);
            check_value("block_read_rdy", 64'd0, block_read_rdy);
        end
        check_value("mac_rdy", 64'd0, mac_rdy);
        wait_full();
        read_block(`DOT_DEPTH);

        repeat (4) next_cycle();
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// ==========================================================
// 8 ns clock. rst_n held low for 8 cycles, released after an edge
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // Free-running clock, 4 ns per half period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Release lines up with the 1 ns stimulus offset
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: dnn_accelerator.sv
// ==========================================================
// Dot-product accelerator with a 64-entry result memory
// Fill all 64 entries before a block read is taken
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module dnn_accelerator (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mac_en,
    output logic              mac_rdy,
    input  dot_pkg::operand_t mac_a0,
    input  dot_pkg::operand_t mac_a1,
    input  dot_pkg::operand_t mac_a2,
    input  dot_pkg::operand_t mac_a3,
    input  dot_pkg::operand_t mac_b0,
    input  dot_pkg::operand_t mac_b1,
    input  dot_pkg::operand_t mac_b2,
    input  dot_pkg::operand_t mac_b3,
    input  logic              block_read_en,
    output logic              block_read_rdy,
    output logic              mem_val_valid,
    output dot_pkg::result_t  mem_val_data
);

    // Producer to buffer
    logic             issue;
    logic             result_valid;
    dot_pkg::result_t result_data;

    // Buffer to reader and back
    logic             drain;
    logic             read_en;
    dot_pkg::addr_t   read_addr;
    dot_pkg::result_t read_data;
    logic             drain_last;

    dot_product_pipe u_pipe (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (issue),
        .a0           (mac_a0),
        .a1           (mac_a1),
        .a2           (mac_a2),
        .a3           (mac_a3),
        .b0           (mac_b0),
        .b1           (mac_b1),
        .b2           (mac_b2),
        .b3           (mac_b3),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

    result_buffer u_buffer (
        .clk            (clk),
        .rst_n          (rst_n),
        .mac_en         (mac_en),
        .mac_rdy        (mac_rdy),
        .issue          (issue),
        .result_valid   (result_valid),
        .result_data    (result_data),
        .block_read_rdy (block_read_rdy),
        .block_read_en  (block_read_en),
        .drain          (drain),
        .read_en        (read_en),
        .read_addr      (read_addr),
        .read_data      (read_data),
        .drain_last     (drain_last)
    );

    block_reader u_reader (
        .clk           (clk),
        .rst_n         (rst_n),
        .drain         (drain),
        .read_en       (read_en),
        .read_addr     (read_addr),
        .drain_last    (drain_last),
        .read_data     (read_data),
        .mem_val_valid (mem_val_valid),
        .mem_val_data  (mem_val_data)
    );

endmodule

`default_nettype wire

// File: block_reader.sv
// ==========================================================
// Streams the whole memory while drain is high
// mem_val_valid trails read_en by 2 cycles
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "dot_macros.svh"

module block_reader (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             drain,
    output logic             read_en,
    output dot_pkg::addr_t   read_addr,
    output logic             drain_last,
    input  dot_pkg::result_t read_data,
    output logic             mem_val_valid,
    output dot_pkg::result_t mem_val_data
);

    // Matches the memory read register
    logic read_en_q;

    // One read per cycle for the whole drain
    assign read_en    = drain;
    // Last address ends the drain in the buffer
    assign drain_last = drain && (read_addr == `DOT_ADDR_W'(`DOT_DEPTH - 1));

    // Address steps from 0 and is parked at 0 when idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_addr <= '0;
        end else if (drain) begin
            read_addr <= read_addr + 1'b1;
        end else begin
            read_addr <= '0;
        end
    end

    // ==========================================================
    // Output registers
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_en_q     <= 1'b0;
            mem_val_valid <= 1'b0;
        end else begin
            read_en_q     <= read_en;
            mem_val_valid <= read_en_q;
        end
    end

    // Data lines up with mem_val_valid
    always_ff @(posedge clk) begin
        mem_val_data <= read_data;
    end

endmodule

`default_nettype wire

// File: result_buffer.sv
// ==========================================================
// Accepts at most 64 operations per round. Extra mac_en is dropped
// Results arriving outside the writing state are discarded
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "dot_macros.svh"

module result_buffer (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mac_en,
    output logic             mac_rdy,
    output logic             issue,
    input  logic             result_valid,
    input  dot_pkg::result_t result_data,
    output logic             block_read_rdy,
    input  logic             block_read_en,
    output logic             drain,
    input  logic             read_en,
    input  dot_pkg::addr_t   read_addr,
    output dot_pkg::result_t read_data,
    input  logic             drain_last
);

    dot_pkg::buffer_state_t  state;
    dot_pkg::buffer_state_t  state_nxt;
    logic [`DOT_COUNT_W-1:0] accept_count;
    logic [`DOT_COUNT_W-1:0] write_count;
    logic                    wr_en;
    logic                    last_write;

    dot_pkg::result_t mem [`DOT_DEPTH];

    // ==========================================================
    // Acceptance and status
    // ==========================================================
    // Ready until the round has taken its full quota
    assign mac_rdy = ((state == dot_pkg::BUF_IDLE) || (state == dot_pkg::BUF_WRITING))
                     && (accept_count < `DOT_COUNT_W'(`DOT_DEPTH));
    assign issue   = mac_en && mac_rdy;

    assign wr_en      = result_valid && (state == dot_pkg::BUF_WRITING);
    assign last_write = wr_en && (write_count == `DOT_COUNT_W'(`DOT_DEPTH - 1));

    assign block_read_rdy = (state == dot_pkg::BUF_FULL);
    assign drain          = (state == dot_pkg::BUF_READING);

    // ==========================================================
    // Round FSM
    // ==========================================================
    always_comb begin
        state_nxt = state;
        case (state)
            dot_pkg::BUF_IDLE: begin
                if (issue) begin
                    state_nxt = dot_pkg::BUF_WRITING;
                end
            end
            dot_pkg::BUF_WRITING: begin
                if (last_write) begin
                    state_nxt = dot_pkg::BUF_FULL;
                end
            end
            dot_pkg::BUF_FULL: begin
                if (block_read_en) begin
                    state_nxt = dot_pkg::BUF_READING;
                end
            end
            dot_pkg::BUF_READING: begin
                if (drain_last) begin
                    state_nxt = dot_pkg::BUF_IDLE;
                end
            end
            default: state_nxt = dot_pkg::BUF_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= dot_pkg::BUF_IDLE;
            accept_count <= '0;
            write_count  <= '0;
        end else begin
            state <= state_nxt;
            // End of drain opens a fresh round
            if (drain_last) begin
                accept_count <= '0;
                write_count  <= '0;
            end else begin
                if (issue) begin
                    accept_count <= accept_count + 1'b1;
                end
                if (wr_en) begin
                    write_count <= write_count + 1'b1;
                end
            end
        end
    end

    // ==========================================================
    // Result memory
    // ==========================================================
    // Writes go in arrival order, which is issue order
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[write_count[`DOT_ADDR_W-1:0]] <= result_data;
        end
        // Registered read, data one cycle after read_en
        if (read_en) begin
            read_data <= mem[read_addr];
        end
    end

endmodule

`default_nettype wire

// File: dot_product_pipe.sv
// ==========================================================
// Issue to result_valid is 9 cycles. One operation per cycle
// No back-pressure. Every issued operation yields a result
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

`include "dot_macros.svh"

module dot_product_pipe (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue,
    input  dot_pkg::operand_t a0,
    input  dot_pkg::operand_t a1,
    input  dot_pkg::operand_t a2,
    input  dot_pkg::operand_t a3,
    input  dot_pkg::operand_t b0,
    input  dot_pkg::operand_t b1,
    input  dot_pkg::operand_t b2,
    input  dot_pkg::operand_t b3,
    output logic              result_valid,
    output dot_pkg::result_t  result_data
);

    // ==========================================================
    // Input register and lane multipliers
    // ==========================================================
    dot_pkg::operand_t a_q [`DOT_LANES];
    dot_pkg::operand_t b_q [`DOT_LANES];
    logic              in_valid;

    logic [`DOT_LANES-1:0] lane_valid;
    dot_pkg::product_t     lane_prod [`DOT_LANES];

    // Operands held until the next issue
    always_ff @(posedge clk) begin
        if (issue) begin
            a_q[0] <= a0;
            a_q[1] <= a1;
            a_q[2] <= a2;
            a_q[3] <= a3;
            b_q[0] <= b0;
            b_q[1] <= b1;
            b_q[2] <= b2;
            b_q[3] <= b3;
        end
    end

    for (genvar i = 0; i < `DOT_LANES; i++) begin : g_lane
        lane_multiplier u_mult (
            .clk        (clk),
            .rst_n      (rst_n),
            .valid      (in_valid),
            .a          (a_q[i]),
            .b          (b_q[i]),
            .prod_valid (lane_valid[i]),
            .prod       (lane_prod[i])
        );
    end

    // ==========================================================
    // Adder tree
    // ==========================================================
    dot_pkg::product_t       cap_prod  [`DOT_LANES];
    dot_pkg::product_t       pipe_prod [`DOT_LANES];
    logic [`DOT_PAIR_W-1:0]  sum01;
    logic [`DOT_PAIR_W-1:0]  sum23;
    logic [`DOT_PAIR_W-1:0]  sum01_q;
    logic [`DOT_PAIR_W-1:0]  sum23_q;
    dot_pkg::result_t        total;
    logic                    cap_valid;
    logic                    pipe_valid;
    logic                    sum_valid;
    logic                    sum_q_valid;
    logic                    total_valid;

    // One valid bit per stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_valid     <= 1'b0;
            cap_valid    <= 1'b0;
            pipe_valid   <= 1'b0;
            sum_valid    <= 1'b0;
            sum_q_valid  <= 1'b0;
            total_valid  <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            in_valid     <= issue;
            // All lanes run in lockstep so lane 0 speaks for them
            cap_valid    <= lane_valid[0];
            pipe_valid   <= cap_valid;
            sum_valid    <= pipe_valid;
            sum_q_valid  <= sum_valid;
            total_valid  <= sum_q_valid;
            result_valid <= total_valid;
        end
    end

    always_ff @(posedge clk) begin
        // Capture only on a finished product
        if (lane_valid[0]) begin
            cap_prod <= lane_prod;
        end
        pipe_prod <= cap_prod;
        // Pairwise sums with one carry bit
        sum01     <= {1'b0, pipe_prod[0]} + {1'b0, pipe_prod[1]};
        sum23     <= {1'b0, pipe_prod[2]} + {1'b0, pipe_prod[3]};
        sum01_q   <= sum01;
        sum23_q   <= sum23;
        // Final carry bit lands in bit 33
        total       <= {1'b0, sum01_q} + {1'b0, sum23_q};
        result_data <= total;
    end

endmodule

`default_nettype wire

// File: lane_multiplier.sv
// ==========================================================
// Unsigned 16x16 multiply with a fixed 2-cycle latency
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module lane_multiplier (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid,
    input  dot_pkg::operand_t a,
    input  dot_pkg::operand_t b,
    output logic              prod_valid,
    output dot_pkg::product_t prod
);

    // First stage holds the raw product
    dot_pkg::product_t raw_prod;
    logic              raw_valid;

    // Valid flags for both stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raw_valid  <= 1'b0;
            prod_valid <= 1'b0;
        end else begin
            raw_valid  <= valid;
            prod_valid <= raw_valid;
        end
    end

    // Payload stages run every cycle
    always_ff @(posedge clk) begin
        // Operands widened so the full 32-bit product is kept
        raw_prod <= dot_pkg::product_t'(a) * dot_pkg::product_t'(b);
        // Second stage leaves room for retiming the multiplier
        prod     <= raw_prod;
    end

endmodule

`default_nettype wire

// File: dot_pkg.sv
// ==========================================================
// Shared datapath types. Unsigned values only
// ==========================================================
`default_nettype none

`include "dot_macros.svh"

package dot_pkg;

    // Datapath words
    typedef logic [`DOT_OPERAND_W-1:0] operand_t;
    typedef logic [`DOT_PRODUCT_W-1:0] product_t;
    typedef logic [`DOT_RESULT_W-1:0]  result_t;
    typedef logic [`DOT_ADDR_W-1:0]    addr_t;

    // Round state of the result buffer
    typedef enum logic [1:0] {
        BUF_IDLE    = 2'b00,
        BUF_WRITING = 2'b01,
        BUF_FULL    = 2'b10,
        BUF_READING = 2'b11
    } buffer_state_t;

endpackage

`default_nettype wire

// File: dot_macros.svh
// ==========================================================
// Sizes are fixed. The adder tree assumes exactly 4 lanes
// DOT_ADDR_W and DOT_COUNT_W must track DOT_DEPTH by hand
// ==========================================================
`ifndef DOT_MACROS_SVH
`define DOT_MACROS_SVH

// Vector shape
`define DOT_LANES      4
`define DOT_OPERAND_W  16

// Datapath widths, growing one bit per adder level
`define DOT_PRODUCT_W  32
`define DOT_PAIR_W     33
`define DOT_RESULT_W   34

// Result memory
`define DOT_DEPTH      64
`define DOT_ADDR_W     6
// Counters must reach DOT_DEPTH itself
`define DOT_COUNT_W    7

`endif
